//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal -GUS_DIV=4 -GMS_DIV=5
TOP       := tb_board_top
FILELIST  := filelist.f
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST)) logic/board_defs.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "run did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+logic
logic/wb_bus_pkg.sv
logic/board_io_pkg.sv
logic/board_timebase.sv
logic/wb_ram.sv
logic/wb_io_regs.sv
logic/wb_decode.sv
logic/seg7_scan.sv
logic/button_toggle.sv
logic/board_top.sv
verification/board_properties.sv
verification/tb_board_top.sv

//--- logic/board_defs.svh
// board timing and address constants
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// timebase dividers, board values
// clocks per microsecond strobe at 50 MHz
`define US_DIV 50
// microsecond strobes per millisecond
`define MS_DIV 1000

// word memory, 2**RAM_AW x 16 bit
`define RAM_AW 13

// I/O space byte offsets, address bits 2..0
`define IO_LED   3'd0  // led register, lane 0 only
`define IO_DISP  3'd2  // display digits and points
`define IO_STAT  3'd4  // toggle status, read only
`define IO_MSCNT 3'd6  // millisecond counter, read only

// bus slave select bit
`define IO_SEL_BIT 15

`endif

//--- logic/board_io_pkg.sv
// front panel types
package board_io_pkg;

  // display register as seen on the bus
  //   [3:0]   digit 0
  //   [7:4]   digit 1
  //   [11:8]  digit 2
  //   [14:12] decimal points, one per digit
  //   [15]    spare
  typedef struct packed {
    logic             spare;  // readable, no function
    logic [2:0]       dp;     // decimal points
    logic [2:0][3:0]  dig;    // hex nibbles, dig[0] rightmost
  } disp_reg_t;

  // board pins driven by the subsystem
  typedef struct packed {
    logic [5:0] led;   // LEDs, active high
    logic [7:0] seg;   // segment mask, active low, dp in bit 7
    logic [2:0] dsel;  // digit select, active low
  } panel_t;

  // scanner steps that light a digit, 0..2
  localparam int SCAN_DIGITS = 3;

  // full scan length, steps 3..5 blank
  localparam int SCAN_STEPS = 6;

endpackage

//--- logic/board_timebase.sv
// microsecond and millisecond strobes
`include "board_defs.svh"

module board_timebase
#(
  parameter int US_DIV = `US_DIV,  // clocks per ena_us
  parameter int MS_DIV = `MS_DIV   // ena_us per ena_ms
)
(
  input  logic sys_clk_p,
  input  logic rst_n_i,
  output logic ena_us_o,  // one clock every US_DIV clocks
  output logic ena_ms_o   // coincides with every MS_DIV-th ena_us
);

  localparam int US_W = $clog2(US_DIV + 1);
  localparam int MS_W = $clog2(MS_DIV + 1);

  logic [US_W-1:0] us_cnt;  // clock prescaler
  logic [MS_W-1:0] ms_cnt;  // microsecond counter
  logic            us_wrap;
  logic            ms_wrap;

  assign us_wrap = (us_cnt == US_W'(US_DIV - 1));
  assign ms_wrap = (ms_cnt == MS_W'(MS_DIV - 1));

  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i)
    begin
      us_cnt   <= '0;
      ms_cnt   <= '0;
      ena_us_o <= 1'b0;
      ena_ms_o <= 1'b0;
    end
    else
    begin
      us_cnt   <= us_wrap ? '0 : us_cnt + 1'b1;
      ena_us_o <= us_wrap;             // strobe registered with the wrap
      ena_ms_o <= us_wrap & ms_wrap;   // same cycle as the ena_us
      if (us_wrap)
        ms_cnt <= ms_wrap ? '0 : ms_cnt + 1'b1;  // counts only on us ticks
    end
  end

endmodule

//--- logic/board_top.sv
// board support subsystem top
`include "board_defs.svh"

module board_top
#(
  parameter int US_DIV = `US_DIV,  // simulation uses a short divider
  parameter int MS_DIV = `MS_DIV
)
(
  input  logic                 sys_clk_p,
  input  logic                 rst_n_i,
  input  wb_bus_pkg::wb_req_t  wb_req_i,  // from the bus master
  output wb_bus_pkg::wb_rsp_t  wb_rsp_o,
  input  logic [1:0]           btn_n_i,   // push buttons, low active
  output board_io_pkg::panel_t panel_o
);

  import wb_bus_pkg::*;
  import board_io_pkg::*;

  logic      ena_us;    // microsecond strobe
  logic      ena_ms;    // millisecond strobe
  wb_req_t   ram_req;
  wb_rsp_t   ram_rsp;
  wb_req_t   io_req;
  wb_rsp_t   io_rsp;
  disp_reg_t disp;
  logic [1:0] tog;      // toggle states to status reg

  board_timebase #(.US_DIV(US_DIV), .MS_DIV(MS_DIV)) u_timebase
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n_i),
    .ena_us_o  (ena_us),
    .ena_ms_o  (ena_ms)
  );

  wb_decode u_decode
  (
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp),
    .io_req_o  (io_req),
    .io_rsp_i  (io_rsp)
  );

  wb_ram u_ram
  (
    .sys_clk_p (sys_clk_p),
    .wb_req_i  (ram_req),
    .wb_rsp_o  (ram_rsp)
  );

  wb_io_regs u_io_regs
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n_i),
    .wb_req_i  (io_req),
    .wb_rsp_o  (io_rsp),
    .ena_ms_i  (ena_ms),
    .tog_i     (tog),
    .leds_o    (panel_o.led),  // straight to the pins
    .disp_o    (disp)
  );

  seg7_scan u_scan
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n_i),
    .ena_ms_i  (ena_ms),
    .disp_i    (disp),
    .seg_o     (panel_o.seg),
    .dsel_o    (panel_o.dsel)
  );

  button_toggle u_tog0
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n_i),
    .ena_ms_i  (ena_ms),
    .btn_n_i   (btn_n_i[0]),
    .tog_o     (tog[0])
  );

  button_toggle u_tog1
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n_i),
    .ena_ms_i  (ena_ms),
    .btn_n_i   (btn_n_i[1]),
    .tog_o     (tog[1])
  );

endmodule

//--- logic/button_toggle.sv
// push button toggle bit
module button_toggle
(
  input  logic sys_clk_p,
  input  logic rst_n_i,
  input  logic ena_ms_i,  // sample rate, also the debounce
  input  logic btn_n_i,   // low while pressed
  output logic tog_o
);

  logic smp_q;  // current sample, high = pressed
  logic prv_q;  // sample one ms earlier

  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i)
    begin
      smp_q <= 1'b0;
      prv_q <= 1'b0;
      tog_o <= 1'b0;
    end
    else if (ena_ms_i)
    begin
      smp_q <= ~btn_n_i;
      prv_q <= smp_q;
      if (smp_q & ~prv_q)
        tog_o <= ~tog_o;  // press after release, one ms late
    end
  end

endmodule

//--- logic/seg7_scan.sv
// seven segment digit scanner
module seg7_scan
(
  input  logic                    sys_clk_p,
  input  logic                    rst_n_i,
  input  logic                    ena_ms_i,  // one step per ms
  input  board_io_pkg::disp_reg_t disp_i,
  output logic [7:0]              seg_o,     // active low segments
  output logic [2:0]              dsel_o     // active low digit select
);

  import board_io_pkg::*;

  logic [2:0] step_q;   // 0, 5, 4, 3, 2, 1, 0, ...
  logic [1:0] dig_idx;
  logic       lit;      // step shows a digit

  // segment order g..a in bits 6..0
  function automatic logic [6:0] hex2seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex2seg = 7'h3f;
      4'h1: hex2seg = 7'h06;
      4'h2: hex2seg = 7'h5b;
      4'h3: hex2seg = 7'h4f;
      4'h4: hex2seg = 7'h66;
      4'h5: hex2seg = 7'h6d;
      4'h6: hex2seg = 7'h7d;
      4'h7: hex2seg = 7'h07;
      4'h8: hex2seg = 7'h7f;
      4'h9: hex2seg = 7'h6f;
      4'ha: hex2seg = 7'h77;
      4'hb: hex2seg = 7'h7c;  // lower case b
      4'hc: hex2seg = 7'h39;
      4'hd: hex2seg = 7'h5e;  // lower case d
      4'he: hex2seg = 7'h79;
      default: hex2seg = 7'h71;
    endcase
  endfunction

  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i)
      step_q <= 3'd0;
    else if (ena_ms_i)
      step_q <= (step_q == 3'd0) ? 3'(SCAN_STEPS - 1) : step_q - 3'd1;  // counts down
  end

  assign lit     = (step_q < 3'(SCAN_DIGITS));
  assign dig_idx = step_q[1:0];

  // blank steps dim the display to half duty
  assign seg_o  = lit ? ~{disp_i.dp[dig_idx], hex2seg(disp_i.dig[dig_idx])} : 8'hff;
  assign dsel_o = lit ? ~(3'b001 << dig_idx) : 3'b111;

endmodule

//--- logic/wb_bus_pkg.sv
// wishbone bus types
package wb_bus_pkg;

  // master to slave, held until ack
  typedef struct packed {
    logic [15:0] adr;  // byte address
    logic [15:0] dat;  // write data
    logic [1:0]  sel;  // byte lanes, [1] high byte
    logic        we;   // write enable
    logic        cyc;  // bus cycle in progress
    logic        stb;  // transfer strobe
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic [15:0] dat;  // read data, valid with ack
    logic        ack;  // transfer acknowledge
  } wb_rsp_t;

  // idle response for unselected slave
  localparam wb_rsp_t WB_RSP_IDLE = '{dat: 16'h0000, ack: 1'b0};

endpackage

//--- logic/wb_decode.sv
// memory and register split of the bus
`include "board_defs.svh"

module wb_decode
(
  input  wb_bus_pkg::wb_req_t wb_req_i,   // from the master
  output wb_bus_pkg::wb_rsp_t wb_rsp_o,
  output wb_bus_pkg::wb_req_t ram_req_o,  // lower half of the map
  input  wb_bus_pkg::wb_rsp_t ram_rsp_i,
  output wb_bus_pkg::wb_req_t io_req_o,   // upper half
  input  wb_bus_pkg::wb_rsp_t io_rsp_i
);

  logic io_sel;  // address in I/O space

  assign io_sel = wb_req_i.adr[`IO_SEL_BIT];

  // only the selected slave sees stb, the rest of the request is shared
  always_comb
  begin
    ram_req_o     = wb_req_i;
    io_req_o      = wb_req_i;
    ram_req_o.stb = wb_req_i.stb & ~io_sel;
    io_req_o.stb  = wb_req_i.stb & io_sel;
  end

  // response back from the slave that owns the address
  assign wb_rsp_o = io_sel ? io_rsp_i : ram_rsp_i;

endmodule

//--- logic/wb_io_regs.sv
// panel and status registers on wishbone
`include "board_defs.svh"

module wb_io_regs
(
  input  logic                    sys_clk_p,
  input  logic                    rst_n_i,
  input  wb_bus_pkg::wb_req_t     wb_req_i,
  output wb_bus_pkg::wb_rsp_t     wb_rsp_o,
  input  logic                    ena_ms_i,  // millisecond strobe
  input  logic [1:0]              tog_i,     // button toggle states
  output logic [5:0]              leds_o,
  output board_io_pkg::disp_reg_t disp_o
);

  import board_io_pkg::*;

  logic [5:0]  led_q;
  disp_reg_t   disp_q;
  logic [15:0] ms_cnt;    // free running, wraps
  logic [15:0] rd_mux;
  logic [15:0] rd_q;
  logic [15:0] disp_wr;   // lane merged display word
  logic [1:0]  ack_q;
  logic [2:0]  off;       // offset inside I/O space
  logic        req;
  logic        wr;

  assign off = wb_req_i.adr[2:0];
  assign req = wb_req_i.cyc & wb_req_i.stb;
  assign wr  = req & wb_req_i.we;

  assign disp_wr[7:0]  = wb_req_i.sel[0] ? wb_req_i.dat[7:0]  : disp_q[7:0];
  assign disp_wr[15:8] = wb_req_i.sel[1] ? wb_req_i.dat[15:8] : disp_q[15:8];

  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i)
    begin
      led_q  <= '0;
      disp_q <= '0;
      ms_cnt <= '0;
    end
    else
    begin
      if (wr && off == `IO_LED && wb_req_i.sel[0])
        led_q <= wb_req_i.dat[5:0];  // high lane has no bits here
      if (wr && off == `IO_DISP)
        disp_q <= disp_reg_t'(disp_wr);
      if (ena_ms_i)
        ms_cnt <= ms_cnt + 16'd1;
    end
  end

  // read mux, stat and counter are read only
  always_comb
  begin
    case (off)
      `IO_LED:   rd_mux = {10'd0, led_q};
      `IO_DISP:  rd_mux = disp_q;
      `IO_STAT:  rd_mux = {14'd0, tog_i};
      `IO_MSCNT: rd_mux = ms_cnt;
      default:   rd_mux = 16'h0000;  // odd byte addresses
    endcase
  end

  // capture while the request is held, settled by the third cycle
  always_ff @(posedge sys_clk_p)
  begin
    if (req)
      rd_q <= rd_mux;
  end

  // same two-stage ack pipe as the memory
  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i)
      ack_q <= 2'b00;
    else
    begin
      ack_q[0] <= req;
      ack_q[1] <= req & ack_q[0];
    end
  end

  assign wb_rsp_o.dat = rd_q;
  assign wb_rsp_o.ack = req & (ack_q[1] | wb_req_i.we);

  assign leds_o = led_q;
  assign disp_o = disp_q;

endmodule

//--- logic/wb_ram.sv
// byte lane word memory on wishbone
`include "board_defs.svh"

module wb_ram
(
  input  logic                sys_clk_p,
  input  wb_bus_pkg::wb_req_t wb_req_i,
  output wb_bus_pkg::wb_rsp_t wb_rsp_o
);

  localparam int DEPTH = 2 ** `RAM_AW;

  logic [15:0]        mem [DEPTH];  // 16-bit words
  logic [`RAM_AW-1:0] waddr;        // word address
  logic [15:0]        rd_q;         // registered read word
  logic [1:0]         ack_q;        // read latency pipe
  logic               req;
  logic [1:0]         lane_we;

  assign waddr   = wb_req_i.adr[`RAM_AW:1];    // byte address to word
  assign req     = wb_req_i.cyc & wb_req_i.stb;
  assign lane_we = wb_req_i.we ? wb_req_i.sel : 2'b00;

  // each lane written on its own
  always_ff @(posedge sys_clk_p)
  begin
    if (req)
    begin
      if (lane_we[0])
        mem[waddr][7:0] <= wb_req_i.dat[7:0];
      if (lane_we[1])
        mem[waddr][15:8] <= wb_req_i.dat[15:8];
      rd_q <= mem[waddr];  // old data on write, unused then
    end
  end

  // first stage set by the request, second when it is still there
  // stb dropped after ack empties the pipe before the next request
  always_ff @(posedge sys_clk_p)
  begin
    ack_q[0] <= req;
    ack_q[1] <= req & ack_q[0];
  end

  assign wb_rsp_o.dat = rd_q;
  assign wb_rsp_o.ack = req & (ack_q[1] | wb_req_i.we);  // write acks at once

endmodule

//--- verification/board_properties.sv
// bus, scanner and timebase properties
`include "board_defs.svh"

module board_properties
#(
  parameter int MS_DIV = `MS_DIV  // ena_us per ena_ms
)
(
  input logic                    sys_clk_p,
  input logic                    rst_n_i,
  input wb_bus_pkg::wb_req_t     wb_req_i,
  input wb_bus_pkg::wb_rsp_t     wb_rsp_i,
  input board_io_pkg::panel_t    panel_i,
  input board_io_pkg::disp_reg_t disp_i,    // display register inside the top
  input logic                    ena_us_i,
  input logic                    ena_ms_i
);

  import wb_bus_pkg::*;
  import board_io_pkg::*;

  // segments g..a for 0..f, lower case b and d
  localparam logic [6:0] SEG_TAB [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  int unsigned err_cnt = 0;  // seen by the testbench
  logic [1:0]  held;         // earlier cycles of this request
  logic [1:0]  lit_idx;      // digit with its select low
  logic [15:0] us_seen;      // ena_us since the last ena_ms
  logic        req;

  assign req     = wb_req_i.cyc & wb_req_i.stb;
  assign lit_idx = !panel_i.dsel[0] ? 2'd0 : (!panel_i.dsel[1] ? 2'd1 : 2'd2);

  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i || !req)
      held <= 2'd0;
    else if (held != 2'd3)
      held <= held + 2'd1;  // saturates
  end

  // coincident ena_us not counted, it starts the next period
  always_ff @(posedge sys_clk_p)
  begin
    if (!rst_n_i || ena_ms_i)
      us_seen <= '0;
    else if (ena_us_i)
      us_seen <= us_seen + 16'd1;
  end

  function void flag_error(input string what);
    err_cnt++;
    $error("%s", what);
  endfunction

  a_wr_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    req && wb_req_i.we |-> wb_rsp_i.ack)
    else flag_error("write not acknowledged in its first cycle");
  // read ack only in the third cycle
  a_rd_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    req && !wb_req_i.we |-> wb_rsp_i.ack == (held == 2'd2))
    else flag_error("read acknowledge outside the third request cycle");
  a_no_ack: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    !wb_req_i.stb |-> !wb_rsp_i.ack)
    else flag_error("acknowledge without strobe");
  a_one_sel: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    $countones(~panel_i.dsel) <= 1)
    else flag_error("more than one digit selected");
  a_blank: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    &panel_i.dsel |-> panel_i.seg == 8'hff)
    else flag_error("segments lit in a blank step");
  a_digit: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    !(&panel_i.dsel) |-> panel_i.seg == ~{disp_i.dp[lit_idx], SEG_TAB[disp_i.dig[lit_idx]]})
    else flag_error("segments do not match the selected digit");
  a_ms_period: assert property (@(posedge sys_clk_p) disable iff (!rst_n_i)
    ena_ms_i |-> ena_us_i && us_seen == 16'(MS_DIV - 1))
    else flag_error("millisecond strobe not on the expected microsecond strobe");

endmodule

// attach to every board_top
bind board_top board_properties #(.MS_DIV(MS_DIV)) u_props
(
  .sys_clk_p (sys_clk_p),
  .rst_n_i   (rst_n_i),
  .wb_req_i  (wb_req_i),
  .wb_rsp_i  (wb_rsp_o),
  .panel_i   (panel_o),
  .disp_i    (disp),
  .ena_us_i  (ena_us),
  .ena_ms_i  (ena_ms)
);

//--- verification/tb_board_top.sv
// board subsystem testbench
`include "board_defs.svh"

module tb_board_top
#(
  parameter int US_DIV = `US_DIV,  // shortened from the Makefile
  parameter int MS_DIV = `MS_DIV
);

  import wb_bus_pkg::*;
  import board_io_pkg::*;

  localparam int MS_CYC = US_DIV * MS_DIV;              // clocks per ms strobe
  localparam int LIMIT  = 40 * 5 + 12 * MS_CYC + 20;    // 40 transfers, 12 ms, reset
  localparam int NWORDS = 8;                            // ram words under test
  localparam logic [12:0] IO_BASE = 13'h1000;           // address bit 15 set

  logic        sys_clk_p;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic [1:0]  btn_n;                   // low while pressed
  panel_t      panel;
  logic [31:0] rng = 32'h9d2fdfd0;      // lcg state
  int          cycles = 0;
  logic [15:0] model [logic [15:0]];    // expected ram words
  logic [15:0] adr_q [$];               // addresses written so far

  board_top #(.US_DIV(US_DIV), .MS_DIV(MS_DIV)) i_dut
  (
    .sys_clk_p (sys_clk_p),
    .rst_n_i   (rst_n),
    .wb_req_i  (wb_req),
    .wb_rsp_o  (wb_rsp),
    .btn_n_i   (btn_n),
    .panel_o   (panel)
  );

  initial
  begin
    sys_clk_p = 1'b0;
    forever #10 sys_clk_p = ~sys_clk_p;  // 20 unit period
  end

  function automatic logic [15:0] lcg_word();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng[31:16];  // upper half, better period
  endfunction

  // byte lane merge of a write into the old word
  function automatic logic [15:0] merge_lanes(input logic [15:0] old, input logic [15:0] dat,
                                              input logic [1:0] sel);
    return {sel[1] ? dat[15:8] : old[15:8], sel[0] ? dat[7:0] : old[7:0]};
  endfunction

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp)
    else
    begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // one wishbone transfer, held until ack
  task automatic bus_transfer(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                              input logic [1:0] sel, output logic [15:0] rdat);
    @(posedge sys_clk_p);
    wb_req.adr <= adr;
    wb_req.dat <= dat;
    wb_req.sel <= sel;
    wb_req.we  <= we;
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    do
      @(posedge sys_clk_p);
    while (!wb_rsp.ack);  // cycle counter covers a missing ack
    rdat = wb_rsp.dat;    // valid with ack
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;   // idle cycle after ack
  endtask

  // two ms held, two ms released
  task automatic press_button(input int b);
    @(posedge sys_clk_p);
    btn_n[b] <= 1'b0;
    repeat (2 * MS_CYC) @(posedge sys_clk_p);
    btn_n[b] <= 1'b1;
    repeat (2 * MS_CYC) @(posedge sys_clk_p);  // flip settles, release sampled
  endtask

  always @(posedge sys_clk_p)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout: the test did not finish within %0d clock cycles", LIMIT);
      abort_run();
    end
    else if (i_dut.u_props.err_cnt != 0)
    begin
      $display("a bus, scanner or timebase property failed at %0t", $time);
      abort_run();
    end
  end

  initial
  begin
    logic [15:0] a;
    logic [15:0] d;
    logic [15:0] got;
    logic [15:0] first;
    logic [1:0]  sel;
    wb_req = '0;
    btn_n  = 2'b11;
    rst_n  = 1'b0;
    repeat (4) @(posedge sys_clk_p);
    rst_n <= 1'b1;

    // full words first, every lane merge then has a known base
    for (int i = 0; i < NWORDS; i++)
    begin
      d = lcg_word();
      a = {2'b00, d[13:1], 1'b0};  // even, no ram alias bit
      d = lcg_word();
      bus_transfer(1'b1, a, d, 2'b11, got);
      model[a] = d;
      adr_q.push_back(a);
    end
    for (int i = 0; i < NWORDS; i += 2)
    begin
      d   = lcg_word();
      sel = (i % 4 == 0) ? 2'b01 : 2'b10;  // low or high lane only
      bus_transfer(1'b1, adr_q[i], d, sel, got);
      model[adr_q[i]] = merge_lanes(model[adr_q[i]], d, sel);
    end
    foreach (adr_q[i])
    begin
      bus_transfer(1'b0, adr_q[i], 16'h0000, 2'b11, got);
      check_eq($sformatf("ram[%h]", adr_q[i]), got, model[adr_q[i]]);
    end

    d = lcg_word();
    bus_transfer(1'b1, {IO_BASE, `IO_LED}, d, 2'b01, got);
    @(posedge sys_clk_p);
    check_eq("panel_o.led", {10'd0, panel.led}, {10'd0, d[5:0]});

    // digits for the scanner checks during the rest of the run
    d = lcg_word();
    bus_transfer(1'b1, {IO_BASE, `IO_DISP}, d, 2'b11, got);
    bus_transfer(1'b0, {IO_BASE, `IO_DISP}, 16'h0000, 2'b11, got);
    check_eq("IO_DISP", got, d);  // scanner sees what was written

    // both reads sample at the same strobe phase
    bus_transfer(1'b0, {IO_BASE, `IO_MSCNT}, 16'h0000, 2'b11, first);
    repeat (3 * MS_CYC - 4) @(posedge sys_clk_p);
    bus_transfer(1'b0, {IO_BASE, `IO_MSCNT}, 16'h0000, 2'b11, got);
    check_eq("IO_MSCNT delta", got - first, 16'd3);

    press_button(0);
    bus_transfer(1'b0, {IO_BASE, `IO_STAT}, 16'h0000, 2'b11, got);
    check_eq("IO_STAT", got, 16'h0001);
    press_button(0);  // flips back
    bus_transfer(1'b0, {IO_BASE, `IO_STAT}, 16'h0000, 2'b11, got);
    check_eq("IO_STAT", got, 16'h0000);

    if (i_dut.u_props.err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
